//--- Bender.yml
package:
  name: rename_dispatch

sources:
  - source/rv32i_pkg.sv
  - source/rename_pkg.sv
  - source/rename_ifs.sv
  - source/inst_queue.sv
  - source/free_list.sv
  - source/rat.sv
  - source/rename_dispatch.sv
  - source/rename_top.sv
  - target: test
    files:
      - dv/rename_tb.sv

//--- compile.f
source/rv32i_pkg.sv
source/rename_pkg.sv
source/rename_ifs.sv
source/inst_queue.sv
source/free_list.sv
source/rat.sv
source/rename_dispatch.sv
source/rename_top.sv
dv/rename_tb.sv

//--- dv/rename_tb.sv
module rename_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        rv32i_pkg::word_t inst;
        rv32i_pkg::word_t pc;
        logic             bp;
        rv32i_pkg::word_t bp_addr;
    } pushed_t;

    localparam rv32i_pkg::opcode_t opcode_list [9] = '{
        rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal, rv32i_pkg::op_jalr,
        rv32i_pkg::op_br, rv32i_pkg::op_load, rv32i_pkg::op_store, rv32i_pkg::op_imm,
        rv32i_pkg::op_reg
    };

    logic clk = 1'b0;
    logic rst, in_valid, in_bp, in_ready, rob_full, global_branch_signal;
    logic ret_valid, wb_valid, dispatch_valid, dispatch_ps1_ready, dispatch_ps2_ready;
    rv32i_pkg::word_t in_inst, in_pc, in_bp_addr, global_branch_addr, dispatch_pc_wdata;
    logic [rename_pkg::NUM_CLASSES-1:0] rs_full;
    rename_pkg::rob_idx_t    rob_num, dispatch_rob_num;
    rename_pkg::mem_idx_t    mem_idx, dispatch_mem_idx;
    rename_pkg::phys_reg_t   ret_preg, wb_preg, dispatch_pd, dispatch_ps1, dispatch_ps2;
    rv32i_pkg::decode_info_t dispatch_info;
    rename_pkg::rs_class_t   dispatch_class;

    // reference model state
    pushed_t                       exp_q [$];
    rename_pkg::phys_reg_t         free_q [$];
    rename_pkg::phys_reg_t         map_m [32];
    logic [rename_pkg::NUM_PHYS-1:0] ready_m;
    rv32i_pkg::word_t              next_pc = 32'h0000_1000;
    logic                          stall_expected = 1'b0;
    int                            checks = 0;
    int                            errors = 0;

    always #2 clk = ~clk;

    rename_top UUT (
        .clk, .rst, .in_valid, .in_inst, .in_pc, .in_bp, .in_bp_addr, .in_ready,
        .rob_full, .rs_full, .rob_num, .mem_idx, .global_branch_signal,
        .global_branch_addr, .ret_valid, .ret_preg, .wb_valid, .wb_preg,
        .dispatch_valid, .dispatch_info, .dispatch_class, .dispatch_pd,
        .dispatch_ps1, .dispatch_ps2, .dispatch_ps1_ready, .dispatch_ps2_ready,
        .dispatch_rob_num, .dispatch_mem_idx, .dispatch_pc_wdata
    );

    no_dispatch_while_stalled: assert property (
        @(posedge clk) disable iff (rst) stall_expected |-> !dispatch_valid
    ) else begin
        $display("FAIL dispatch_valid exp=0x0 got=0x%h", dispatch_valid);
        errors++;
    end

    function automatic rv32i_pkg::word_t make_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // funct7 = 1 on a reg op marks the M group and funct3[2] splits mul from div
    function automatic rename_pkg::rs_class_t expected_class(input rv32i_pkg::word_t inst);
        if (inst[6:0] == rv32i_pkg::op_reg && inst[31:25] == 7'd1) begin
            return inst[14] ? rename_pkg::cls_div : rename_pkg::cls_mul;
        end
        case (inst[6:0])
            rv32i_pkg::op_jal, rv32i_pkg::op_jalr, rv32i_pkg::op_br: return rename_pkg::cls_br;
            rv32i_pkg::op_load, rv32i_pkg::op_store: return rename_pkg::cls_mem;
            default: return rename_pkg::cls_alu;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s exp=0x%h got=0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_dispatch();
        pushed_t               e;
        rv32i_pkg::word_t      i;
        rename_pkg::rs_class_t cls;
        rename_pkg::phys_reg_t pd;
        logic                  needs_rd;
        if (exp_q.size() == 0) begin
            $display("a dispatch appeared with no instruction outstanding");
            errors++;
            return;
        end
        e = exp_q.pop_front();
        i = e.inst;
        cls = expected_class(i);
        needs_rd = !(i[6:0] inside {rv32i_pkg::op_br, rv32i_pkg::op_store}) && (i[11:7] != 0);
        pd = '0;
        if (needs_rd && free_q.size() == 0) begin
            $display("a destination was renamed with no free register left");
            errors++;
        end else if (needs_rd) begin
            pd = free_q.pop_front();
        end
        compare_field("dispatch_class", cls, dispatch_class);
        compare_field("dispatch_info.inst", i, dispatch_info.inst);
        compare_field("dispatch_info.opcode", i[6:0], dispatch_info.opcode);
        compare_field("dispatch_info.funct3", i[14:12], dispatch_info.funct3);
        compare_field("dispatch_info.funct7", i[31:25], dispatch_info.funct7);
        compare_field("dispatch_info.pc", e.pc, dispatch_info.pc);
        compare_field("dispatch_info.bp", e.bp, dispatch_info.bp);
        compare_field("dispatch_info.bp_addr", e.bp_addr, dispatch_info.bp_addr);
        compare_field("dispatch_info.rd_s", i[11:7], dispatch_info.rd_s);
        compare_field("dispatch_info.rs1_s", i[19:15], dispatch_info.rs1_s);
        compare_field("dispatch_info.rs2_s", i[24:20], dispatch_info.rs2_s);
        compare_field("dispatch_info.i_imm", $signed(i) >>> 20, dispatch_info.i_imm);
        compare_field("dispatch_info.s_imm", {{20{i[31]}}, i[31:25], i[11:7]},
                      dispatch_info.s_imm);
        compare_field("dispatch_info.b_imm", {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0},
                      dispatch_info.b_imm);
        compare_field("dispatch_info.u_imm", i & 32'hffff_f000, dispatch_info.u_imm);
        compare_field("dispatch_info.j_imm",
                      {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0}, dispatch_info.j_imm);
        compare_field("dispatch_pd", pd, dispatch_pd);
        compare_field("dispatch_ps1", map_m[i[19:15]], dispatch_ps1);
        compare_field("dispatch_ps2", map_m[i[24:20]], dispatch_ps2);
        compare_field("dispatch_ps1_ready", ready_m[map_m[i[19:15]]], dispatch_ps1_ready);
        compare_field("dispatch_ps2_ready", ready_m[map_m[i[24:20]]], dispatch_ps2_ready);
        compare_field("dispatch_rob_num", rob_num, dispatch_rob_num);
        compare_field("dispatch_mem_idx", mem_idx, dispatch_mem_idx);
        compare_field("dispatch_pc_wdata", (cls == rename_pkg::cls_br && e.bp) ? e.bp_addr
                      : global_branch_signal ? global_branch_addr : e.pc + 32'd4,
                      dispatch_pc_wdata);
        // sources are read before the destination mapping moves
        if (needs_rd) begin
            map_m[i[11:7]] = pd;
            ready_m[pd] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && dispatch_valid) begin
            check_dispatch();
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        in_bp = 1'b0;
        in_bp_addr = '0;
        rob_full = 1'b0;
        rs_full = '0;
        ret_valid = 1'b0;
        ret_preg = '0;
        wb_valid = 1'b0;
        wb_preg = '0;
        global_branch_signal = 1'b0;
        global_branch_addr = $urandom & 32'hffff_fffc;
        rob_num = $urandom;
        mem_idx = $urandom;
        exp_q.delete();
        free_q.delete();
        for (int r = 0; r < 32; r++) begin
            map_m[r] = rename_pkg::phys_reg_t'(r);
        end
        for (int r = 32; r < rename_pkg::NUM_PHYS; r++) begin
            free_q.push_back(rename_pkg::phys_reg_t'(r));
        end
        ready_m = '1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic push_inst(input rv32i_pkg::word_t inst, input logic bp,
                             input rv32i_pkg::word_t bp_addr);
        int n;
        n = 0;
        in_valid = 1'b1;
        in_inst = inst;
        in_pc = next_pc;
        in_bp = bp;
        in_bp_addr = bp_addr;
        while (!in_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("timeout: the instruction queue never accepted an instruction");
            errors++;
        end else begin
            exp_q.push_back('{inst: inst, pc: next_pc, bp: bp, bp_addr: bp_addr});
        end
        @(negedge clk);
        in_valid = 1'b0;
        next_pc += 32'd4;
    endtask

    task automatic return_preg(input rename_pkg::phys_reg_t preg);
        ret_valid = 1'b1;
        ret_preg = preg;
        free_q.push_back(preg);
        @(negedge clk);
        ret_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d instructions never dispatched", exp_q.size());
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic random_phase(input logic redirect, input int count);
        rv32i_pkg::word_t inst;
        global_branch_signal = redirect;
        for (int k = 0; k < count; k++) begin
            inst = $urandom;
            inst[6:0] = opcode_list[k % 9];
            if (inst[6:0] == rv32i_pkg::op_reg && $urandom_range(0, 1) == 1) begin
                inst[31:25] = 7'h01;
            end
            push_inst(inst, $urandom_range(0, 1), $urandom & 32'hffff_fffc);
        end
        wait_drain(100);
    endtask

    task automatic dependency_chain();
        push_inst(make_inst(7'h00, 5'd2, 5'd1, 3'd0, 5'd1, rv32i_pkg::op_reg), 1'b0, '0);
        push_inst(make_inst(7'h00, 5'd1, 5'd1, 3'd0, 5'd3, rv32i_pkg::op_reg), 1'b0, '0);
        push_inst(make_inst(7'h00, 5'd1, 5'd3, 3'd0, 5'd1, rv32i_pkg::op_reg), 1'b0, '0);
        push_inst(make_inst(7'h00, 5'd3, 5'd1, 3'd2, 5'd4, rv32i_pkg::op_store), 1'b0, '0);
        push_inst(make_inst(7'h00, 5'd3, 5'd1, 3'd0, 5'd8, rv32i_pkg::op_br), 1'b1, 32'h2000);
        push_inst(make_inst(7'h00, 5'd3, 5'd1, 3'd0, 5'd0, rv32i_pkg::op_reg), 1'b0, '0);
        wait_drain(40);
        // wake the latest x1 producer and leave x3 pending
        wb_valid = 1'b1;
        wb_preg = map_m[1];
        ready_m[map_m[1]] = 1'b1;
        @(negedge clk);
        wb_valid = 1'b0;
        push_inst(make_inst(7'h00, 5'd3, 5'd1, 3'd0, 5'd5, rv32i_pkg::op_reg), 1'b0, '0);
        wait_drain(40);
    endtask

    task automatic hold_and_release();
        // mul at the head with its station full blocks everything behind it
        rs_full[rename_pkg::cls_mul] = 1'b1;
        stall_expected = 1'b1;
        push_inst(make_inst(7'h01, 5'd2, 5'd1, 3'd0, 5'd6, rv32i_pkg::op_reg), 1'b0, '0);
        for (int k = 0; k < 7; k++) begin
            push_inst(make_inst(7'h00, 5'd6, 5'd7, 3'd0, 5'(k + 8), rv32i_pkg::op_reg), 1'b0, '0);
        end
        compare_field("in_ready", 1'b0, in_ready);
        repeat (6) @(negedge clk);
        stall_expected = 1'b0;
        rs_full = '0;
        wait_drain(40);
        rob_full = 1'b1;
        repeat (2) @(negedge clk);
        stall_expected = 1'b1;
        for (int k = 0; k < 4; k++) begin
            push_inst(make_inst(7'h00, 5'd8, 5'd9, 3'd0, 5'(k + 20), rv32i_pkg::op_imm), 1'b0, '0);
        end
        repeat (6) @(negedge clk);
        stall_expected = 1'b0;
        rob_full = 1'b0;
        wait_drain(40);
    endtask

    task automatic exhaust_free_list();
        int n;
        n = 0;
        for (int k = 0; k < 34; k++) begin
            push_inst(make_inst(7'h00, 5'd2, 5'd3, 3'd0, 5'((k % 31) + 1), rv32i_pkg::op_reg),
                      1'b0, '0);
        end
        while (exp_q.size() > 2 && n < 100) begin
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        stall_expected = 1'b1;
        repeat (5) @(negedge clk);
        assert (exp_q.size() == 2) else begin
            $display("free list ran dry with %0d instructions queued instead of 2",
                     exp_q.size());
            errors++;
        end
        stall_expected = 1'b0;
        // one returned register lets exactly one instruction through
        return_preg(6'd7);
        n = 0;
        while (exp_q.size() > 1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        stall_expected = 1'b1;
        repeat (5) @(negedge clk);
        assert (exp_q.size() == 1) else begin
            $display("one returned register left %0d instructions queued instead of 1",
                     exp_q.size());
            errors++;
        end
        stall_expected = 1'b0;
        return_preg(6'd9);
        wait_drain(20);
        repeat (4) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h67aadb67));
        apply_reset();
        random_phase(1'b0, 27);
        apply_reset();
        random_phase(1'b1, 27);
        apply_reset();
        dependency_chain();
        apply_reset();
        hold_and_release();
        apply_reset();
        exhaust_free_list();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- source/free_list.sv
module free_list #(
    parameter int NUM_PHYS = rename_pkg::NUM_PHYS
) (
    input logic       clk,
    input logic       rst,
    free_list_if.list fl,
    free_list_if.ret  ret
);

    localparam int PTR_W    = $clog2(NUM_PHYS);
    localparam int CNT_W    = PTR_W + 1;
    // registers 0..31 start out mapped in the RAT
    localparam int NUM_FREE = NUM_PHYS - 32;

    rename_pkg::phys_reg_t slots [NUM_PHYS];
    logic [PTR_W-1:0]      head;
    logic [PTR_W-1:0]      tail;
    logic [CNT_W-1:0]      count;
    logic                  push;
    logic                  pull;

    assign pull     = fl.alloc;
    assign push     = ret.ret_valid;
    assign fl.preg  = slots[head];
    assign fl.empty = (count == '0);

    // reset loads the unmapped registers in order
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_FREE; i++) begin
                slots[i] <= rename_pkg::phys_reg_t'(i + 32);
            end
        end else if (push) begin
            slots[tail] <= ret.ret_preg;
        end
    end

    // x0 never gets a destination, so p0 never comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= PTR_W'(NUM_FREE);
            count <= CNT_W'(NUM_FREE);
        end else begin
            if (pull) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pull);
        end
    end

endmodule

//--- source/inst_queue.sv
module inst_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  rv32i_pkg::word_t in_inst,
    input  rv32i_pkg::word_t in_pc,
    input  logic             in_bp,
    input  rv32i_pkg::word_t in_bp_addr,
    output logic             in_ready,
    input  logic             pop,
    output rv32i_pkg::word_t head_inst,
    output rv32i_pkg::word_t head_pc,
    output logic             head_bp,
    output rv32i_pkg::word_t head_bp_addr,
    output logic             empty
);

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    typedef struct packed {
        rv32i_pkg::word_t inst;
        rv32i_pkg::word_t pc;
        logic             bp;
        rv32i_pkg::word_t bp_addr;
    } iq_entry_t;

    iq_entry_t        entries [IQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;

    assign in_ready = (count < CNT_W'(IQ_DEPTH));
    assign empty    = (count == '0);
    assign push     = in_valid && in_ready;

    // head is read straight out of the buffer
    assign head_inst    = entries[rd_ptr].inst;
    assign head_pc      = entries[rd_ptr].pc;
    assign head_bp      = entries[rd_ptr].bp;
    assign head_bp_addr = entries[rd_ptr].bp_addr;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= '{inst: in_inst, pc: in_pc, bp: in_bp, bp_addr: in_bp_addr};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // wrap by compare so any depth works
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

//--- source/rat.sv
module rat #(
    parameter int NUM_PHYS = rename_pkg::NUM_PHYS
) (
    input logic clk,
    input logic rst,
    rat_if.tbl  rt,
    rat_if.wb   wb
);

    rename_pkg::phys_reg_t map [32];
    logic [NUM_PHYS-1:0]   ready;

    // combinational source lookup
    assign rt.ps1       = map[rt.rs1];
    assign rt.ps2       = map[rt.rs2];
    assign rt.ps1_ready = ready[map[rt.rs1]];
    assign rt.ps2_ready = ready[map[rt.rs2]];

    // identity mapping out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (rt.we) begin
            map[rt.rd] <= rt.pd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
        end else begin
            if (wb.wb_valid) begin
                ready[wb.wb_preg] <= 1'b1;
            end
            // rename clear wins over a same-cycle wakeup
            if (rt.we) begin
                ready[rt.pd] <= 1'b0;
            end
        end
    end

endmodule

//--- source/rename_dispatch.sv
module rename_dispatch (
    input  logic                        clk,
    input  logic                        rst,
    input  rv32i_pkg::word_t            head_inst,
    input  rv32i_pkg::word_t            head_pc,
    input  logic                        head_bp,
    input  rv32i_pkg::word_t            head_bp_addr,
    input  logic                        empty,
    input  logic                        rob_full,
    input  logic [rename_pkg::NUM_CLASSES-1:0] rs_full,
    input  rename_pkg::rob_idx_t        rob_num,
    input  rename_pkg::mem_idx_t        mem_idx,
    input  logic                        global_branch_signal,
    input  rv32i_pkg::word_t            global_branch_addr,
    output logic                        pop,
    free_list_if.stage                  fl,
    rat_if.stage                        rt,
    output logic                        dispatch_valid,
    output rv32i_pkg::decode_info_t     dispatch_info,
    output rename_pkg::rs_class_t       dispatch_class,
    output rename_pkg::phys_reg_t       dispatch_pd,
    output rename_pkg::phys_reg_t       dispatch_ps1,
    output rename_pkg::phys_reg_t       dispatch_ps2,
    output logic                        dispatch_ps1_ready,
    output logic                        dispatch_ps2_ready,
    output rename_pkg::rob_idx_t        dispatch_rob_num,
    output rename_pkg::mem_idx_t        dispatch_mem_idx,
    output rv32i_pkg::word_t            dispatch_pc_wdata
);

    rv32i_pkg::decode_info_t info;
    rename_pkg::rs_class_t   cls;
    rv32i_pkg::word_t        pc_next;
    logic                    rob_full_q;
    logic                    is_md;
    logic                    needs_rd;
    logic                    fire;

    // field extraction for the head instruction
    always_comb begin
        info         = '0;
        info.opcode  = rv32i_pkg::opcode_t'(head_inst[6:0]);
        info.funct3  = head_inst[14:12];
        info.funct7  = head_inst[31:25];
        info.i_imm   = {{21{head_inst[31]}}, head_inst[30:20]};
        info.s_imm   = {{21{head_inst[31]}}, head_inst[30:25], head_inst[11:7]};
        info.b_imm   = {{20{head_inst[31]}}, head_inst[7], head_inst[30:25],
                        head_inst[11:8], 1'b0};
        info.u_imm   = {head_inst[31:12], 12'h000};
        info.j_imm   = {{12{head_inst[31]}}, head_inst[19:12], head_inst[20],
                        head_inst[30:21], 1'b0};
        info.rd_s    = head_inst[11:7];
        info.rs1_s   = head_inst[19:15];
        info.rs2_s   = head_inst[24:20];
        info.inst    = head_inst;
        info.pc      = head_pc;
        info.bp      = head_bp;
        info.bp_addr = head_bp_addr;
    end

    assign is_md = (head_inst[6:0] == rv32i_pkg::op_reg)
                && (head_inst[31:25] == rv32i_pkg::f7_muldiv);

    always_comb begin
        if (is_md && (head_inst[14:12] inside {rv32i_pkg::f3_mul, rv32i_pkg::f3_mulh,
                                               rv32i_pkg::f3_mulhsu, rv32i_pkg::f3_mulhu})) begin
            cls = rename_pkg::cls_mul;
        end else if (is_md && (head_inst[14:12] inside {rv32i_pkg::f3_div, rv32i_pkg::f3_divu,
                                                        rv32i_pkg::f3_rem, rv32i_pkg::f3_remu})) begin
            cls = rename_pkg::cls_div;
        end else if (info.opcode inside {rv32i_pkg::op_jal, rv32i_pkg::op_jalr,
                                         rv32i_pkg::op_br}) begin
            cls = rename_pkg::cls_br;
        end else if (info.opcode inside {rv32i_pkg::op_load, rv32i_pkg::op_store}) begin
            cls = rename_pkg::cls_mem;
        end else begin
            cls = rename_pkg::cls_alu;
        end
    end

    // branches, stores and x0 writes leave the free list alone
    assign needs_rd = !(info.opcode inside {rv32i_pkg::op_br, rv32i_pkg::op_store})
                   && (info.rd_s != '0);

    assign fire = !empty && (!needs_rd || !fl.empty) && !rob_full_q && !rs_full[cls];

    assign pop      = fire;
    assign fl.alloc = fire && needs_rd;
    assign rt.we    = fire && needs_rd;
    assign rt.rd    = info.rd_s;
    assign rt.pd    = fl.preg;
    assign rt.rs1   = info.rs1_s;
    assign rt.rs2   = info.rs2_s;

    // predicted branch first, then redirect, then fall-through
    assign pc_next = (cls == rename_pkg::cls_br && info.bp) ? info.bp_addr
                   : global_branch_signal ? global_branch_addr
                   : head_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            rob_full_q     <= 1'b0;
            dispatch_valid <= 1'b0;
        end else begin
            rob_full_q     <= rob_full;
            dispatch_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            dispatch_info      <= info;
            dispatch_class     <= cls;
            dispatch_pd        <= needs_rd ? fl.preg : '0;
            dispatch_ps1       <= rt.ps1;
            dispatch_ps2       <= rt.ps2;
            dispatch_ps1_ready <= rt.ps1_ready;
            dispatch_ps2_ready <= rt.ps2_ready;
            dispatch_rob_num   <= rob_num;
            dispatch_mem_idx   <= mem_idx;
            dispatch_pc_wdata  <= pc_next;
        end
    end

endmodule

//--- source/rename_ifs.sv
interface free_list_if;

    logic                  alloc;
    rename_pkg::phys_reg_t preg;
    logic                  empty;
    // committed registers coming back
    logic                  ret_valid;
    rename_pkg::phys_reg_t ret_preg;

    modport stage (output alloc, input preg, input empty);
    modport list (input alloc, output preg, output empty);
    modport ret (input ret_valid, input ret_preg);

endinterface

interface rat_if;

    rv32i_pkg::arch_reg_t  rs1;
    rv32i_pkg::arch_reg_t  rs2;
    rv32i_pkg::arch_reg_t  rd;
    rename_pkg::phys_reg_t pd;
    logic                  we;
    rename_pkg::phys_reg_t ps1;
    rename_pkg::phys_reg_t ps2;
    logic                  ps1_ready;
    logic                  ps2_ready;
    // writeback wakeup
    logic                  wb_valid;
    rename_pkg::phys_reg_t wb_preg;

    modport stage (output rs1, rs2, rd, pd, we, input ps1, ps2, ps1_ready, ps2_ready);
    modport tbl (input rs1, rs2, rd, pd, we, output ps1, ps2, ps1_ready, ps2_ready);
    modport wb (input wb_valid, input wb_preg);

endinterface

//--- source/rename_pkg.sv
package rename_pkg;

    // default physical register count
    localparam int NUM_PHYS = 64;

    // one station per class
    localparam int NUM_CLASSES = 5;

    typedef logic [5:0] phys_reg_t;
    typedef logic [3:0] rob_idx_t;
    typedef logic [2:0] mem_idx_t;

    // reservation-station class and rs_full bit index
    typedef enum logic [2:0] {
        cls_alu = 3'd0,
        cls_mul = 3'd1,
        cls_div = 3'd2,
        cls_br  = 3'd3,
        cls_mem = 3'd4
    } rs_class_t;

endpackage

//--- source/rename_top.sv
module rename_top #(
    parameter int IQ_DEPTH = 8,
    parameter int NUM_PHYS = rename_pkg::NUM_PHYS
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  rv32i_pkg::word_t            in_inst,
    input  rv32i_pkg::word_t            in_pc,
    input  logic                        in_bp,
    input  rv32i_pkg::word_t            in_bp_addr,
    output logic                        in_ready,
    input  logic                        rob_full,
    input  logic [rename_pkg::NUM_CLASSES-1:0] rs_full,
    input  rename_pkg::rob_idx_t        rob_num,
    input  rename_pkg::mem_idx_t        mem_idx,
    input  logic                        global_branch_signal,
    input  rv32i_pkg::word_t            global_branch_addr,
    input  logic                        ret_valid,
    input  rename_pkg::phys_reg_t       ret_preg,
    input  logic                        wb_valid,
    input  rename_pkg::phys_reg_t       wb_preg,
    output logic                        dispatch_valid,
    output rv32i_pkg::decode_info_t     dispatch_info,
    output rename_pkg::rs_class_t       dispatch_class,
    output rename_pkg::phys_reg_t       dispatch_pd,
    output rename_pkg::phys_reg_t       dispatch_ps1,
    output rename_pkg::phys_reg_t       dispatch_ps2,
    output logic                        dispatch_ps1_ready,
    output logic                        dispatch_ps2_ready,
    output rename_pkg::rob_idx_t        dispatch_rob_num,
    output rename_pkg::mem_idx_t        dispatch_mem_idx,
    output rv32i_pkg::word_t            dispatch_pc_wdata
);

    rv32i_pkg::word_t head_inst;
    rv32i_pkg::word_t head_pc;
    rv32i_pkg::word_t head_bp_addr;
    logic             head_bp;
    logic             iq_empty;
    logic             iq_pop;

    free_list_if fl_bus ();
    rat_if       rat_bus ();

    // commit returns and writeback wakeups enter the buses here
    assign fl_bus.ret_valid = ret_valid;
    assign fl_bus.ret_preg  = ret_preg;
    assign rat_bus.wb_valid = wb_valid;
    assign rat_bus.wb_preg  = wb_preg;

    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq (
        .clk, .rst, .in_valid, .in_inst, .in_pc, .in_bp, .in_bp_addr, .in_ready,
        .pop(iq_pop), .head_inst, .head_pc, .head_bp, .head_bp_addr, .empty(iq_empty)
    );

    free_list #(.NUM_PHYS(NUM_PHYS)) u_fl (.clk, .rst, .fl(fl_bus), .ret(fl_bus));

    rat #(.NUM_PHYS(NUM_PHYS)) u_rat (.clk, .rst, .rt(rat_bus), .wb(rat_bus));

    rename_dispatch u_rd (
        .clk, .rst, .head_inst, .head_pc, .head_bp, .head_bp_addr, .empty(iq_empty),
        .rob_full, .rs_full, .rob_num, .mem_idx, .global_branch_signal,
        .global_branch_addr, .pop(iq_pop), .fl(fl_bus), .rt(rat_bus),
        .dispatch_valid, .dispatch_info, .dispatch_class, .dispatch_pd,
        .dispatch_ps1, .dispatch_ps2, .dispatch_ps1_ready, .dispatch_ps2_ready,
        .dispatch_rob_num, .dispatch_mem_idx, .dispatch_pc_wdata
    );

endmodule

//--- source/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  arch_reg_t;

    // RV32 major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // M extension, funct7 and funct3
    localparam logic [6:0] f7_muldiv = 7'b0000001;
    localparam logic [2:0] f3_mul    = 3'b000;
    localparam logic [2:0] f3_mulh   = 3'b001;
    localparam logic [2:0] f3_mulhsu = 3'b010;
    localparam logic [2:0] f3_mulhu  = 3'b011;
    localparam logic [2:0] f3_div    = 3'b100;
    localparam logic [2:0] f3_divu   = 3'b101;
    localparam logic [2:0] f3_rem    = 3'b110;
    localparam logic [2:0] f3_remu   = 3'b111;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      i_imm;
        word_t      s_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
        arch_reg_t  rd_s;
        arch_reg_t  rs1_s;
        arch_reg_t  rs2_s;
        word_t      inst;
        word_t      pc;
        logic       bp;
        word_t      bp_addr;
    } decode_info_t;

endpackage
